//--- sources.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_queue_ctrl.sv
logic/rob_entry_array.sv
logic/rob_retire_unit.sv
logic/rob_top.sv
verif/rob_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the reorder buffer testbench with verilator and run it
# exit status is nonzero when the build fails or the run hits $fatal
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module rob_tb -o rob_sim \
    && ./obj_dir/rob_sim \
    || { echo "reorder buffer simulation failed"; exit 1; }

//--- verif/rob_tb.sv
`default_nettype none

`include "rob_params.svh"

module rob_tb;
    import rob_pkg::*;

    logic clk;
    logic rst_n;
    logic dispatch_valid;
    rob_dispatch_t dispatch_data;
    logic dispatch_ready;
    rob_id_t dispatch_rob_id;
    rob_wb_t iiq_wakeup;
    rob_wb_t alu_wb;
    rob_wb_t ld_wb;
    rob_npc_t alu_npc;
    rob_id_t rd_id_src1;
    rob_id_t rd_id_src2;
    rob_read_t rd_src1;
    rob_read_t rd_src2;
    rob_retire_t retire_out;

    // reference model, slot contents plus program order of live ids
    rob_entry_t mdl [`ROB_N_ENTRIES];
    logic mocc [`ROB_N_ENTRIES];
    rob_id_t inflight[$];
    rob_id_t mtail;
    rob_retire_t exp_ret;
    logic [31:0] lcg_state;

    // scenario counters
    int n_full;
    int n_flush;
    int n_retire;
    int n_silent;
    int n_dual;
    int n_reads;

    rob_top u_rob_top (
        .clk(clk),
        .rst_n(rst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch_data(dispatch_data),
        .dispatch_ready(dispatch_ready),
        .dispatch_rob_id(dispatch_rob_id),
        .iiq_wakeup(iiq_wakeup),
        .alu_wb(alu_wb),
        .ld_wb(ld_wb),
        .alu_npc(alu_npc),
        .rd_id_src1(rd_id_src1),
        .rd_id_src2(rd_id_src2),
        .rd_src1(rd_src1),
        .rd_src2(rd_src2),
        .retire_out(retire_out)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // low lcg bits repeat quickly, so draw from the middle
    function automatic int pick_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    // payload only counts alongside its pulse
    task automatic check_retire(input rob_retire_t got, input rob_retire_t exp);
        logic bad;
        bad = (got.retire !== exp.retire) || (got.redirect_valid !== exp.redirect_valid);
        if (exp.retire && (got.rob_id !== exp.rob_id || got.arf_id !== exp.arf_id
                || got.reg_data !== exp.reg_data)) begin
            bad = 1'b1;
        end
        if (exp.redirect_valid && got.redirect_pc !== exp.redirect_pc) begin
            bad = 1'b1;
        end
        if (bad) begin
            report_fail($sformatf(
                "MISMATCH at %0t: retire_out got ret=%0b id=%0d arf=%0d data=%h rd=%0b pc=%h, %s",
                $time, got.retire, got.rob_id, got.arf_id, got.reg_data, got.redirect_valid,
                got.redirect_pc, $sformatf("expected ret=%0b id=%0d arf=%0d data=%h rd=%0b pc=%h",
                exp.retire, exp.rob_id, exp.arf_id, exp.reg_data, exp.redirect_valid,
                exp.redirect_pc)));
        end
    endtask

    task automatic check_read(input rob_read_t got, input rob_read_t exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH at %0t: %s got ready=%0b data=%h, expected ready=%0b data=%h",
                $time, what, got.reg_ready, got.reg_data, exp.reg_ready, exp.reg_data));
        end
    endtask

    task automatic check_rob_id(input rob_id_t got, input rob_id_t exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH at %0t: %s got %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH at %0t: %s got %0b, expected %0b",
                $time, what, got, exp));
        end
    endtask

    // only live slots have defined contents
    task automatic check_port(input rob_read_t got, input rob_id_t id, input string what);
        rob_read_t exp;
        if (mocc[id]) begin
            exp.reg_ready = mdl[id].reg_ready;
            exp.reg_data = mdl[id].reg_data;
            check_read(got, exp, what);
            n_reads++;
        end
    endtask

    // head action from the model
    function automatic rob_commit_e model_commit();
        rob_entry_t h;
        if (inflight.size() == 0) begin
            return commit_none;
        end
        h = mdl[inflight[0]];
        if (!h.is_executed) begin
            return commit_none;
        end else if (h.br_mispred) begin
            return commit_flush;
        end else if (h.dst_valid) begin
            return commit_reg;
        end
        return commit_silent;
    endfunction

    // one clock: check last edge, drive new inputs, step the model to the next edge
    task automatic run_cycle(input int disp_pct, input int wb_pct, input int misp_pct);
        rob_id_t pending[$];
        rob_entry_t head;
        rob_commit_e cmt;
        logic exp_ready;
        int k;
        @(negedge clk);
        check_retire(retire_out, exp_ret);
        cmt = model_commit();
        exp_ready = (inflight.size() < `ROB_N_ENTRIES) && (cmt != commit_flush);
        check_flag(dispatch_ready, exp_ready, "dispatch_ready");
        check_rob_id(dispatch_rob_id, mtail, "dispatch_rob_id");
        if (inflight.size() == `ROB_N_ENTRIES) begin
            n_full++;
        end

        dispatch_valid = (pick_below(100) < disp_pct);
        dispatch_data.dst_valid = (pick_below(4) != 0);
        dispatch_data.dst_arf_id = arf_id_t'(lcg_next());
        dispatch_data.pc = lcg_next() & 32'hffff_fffc;
        iiq_wakeup = '0;
        alu_wb = '0;
        ld_wb = '0;
        alu_npc = '0;
        // wakeup may hit any live slot, reg_data is junk on purpose
        if (inflight.size() != 0 && pick_below(100) < wb_pct) begin
            iiq_wakeup.valid = 1'b1;
            iiq_wakeup.rob_id = inflight[pick_below(inflight.size())];
            iiq_wakeup.reg_data = lcg_next();
        end
        // alu and load only finish slots that are still waiting
        foreach (inflight[i]) begin
            if (!mdl[inflight[i]].is_executed) begin
                pending.push_back(inflight[i]);
            end
        end
        if (pending.size() != 0 && pick_below(100) < wb_pct) begin
            k = pick_below(pending.size());
            alu_wb.valid = 1'b1;
            alu_wb.rob_id = pending[k];
            alu_wb.reg_data = lcg_next();
            pending.delete(k);
            if (pick_below(100) < 30) begin
                alu_npc.valid = 1'b1;
                alu_npc.mispred = (pick_below(100) < misp_pct);
                alu_npc.npc = lcg_next() & 32'hffff_fffc;
            end
        end
        // distinct from the alu id since it came off the list
        if (pending.size() != 0 && pick_below(100) < wb_pct) begin
            ld_wb.valid = 1'b1;
            ld_wb.rob_id = pending[pick_below(pending.size())];
            ld_wb.reg_data = lcg_next();
        end
        if (alu_wb.valid && ld_wb.valid) begin
            n_dual++;
        end
        rd_id_src1 = rob_id_t'(pick_below(`ROB_N_ENTRIES));
        rd_id_src2 = rob_id_t'(pick_below(`ROB_N_ENTRIES));
        #1;
        check_port(rd_src1, rd_id_src1, "rd_src1");
        check_port(rd_src2, rd_id_src2, "rd_src2");

        // head as the retire unit sees it before this edge
        head = '0;
        if (inflight.size() != 0) begin
            head = mdl[inflight[0]];
        end
        if (iiq_wakeup.valid) begin
            mdl[iiq_wakeup.rob_id].reg_ready = 1'b1;
        end
        if (alu_wb.valid) begin
            mdl[alu_wb.rob_id].reg_data = alu_wb.reg_data;
            mdl[alu_wb.rob_id].is_executed = 1'b1;
            if (alu_npc.valid) begin
                mdl[alu_wb.rob_id].pc_npc = alu_npc.npc;
                mdl[alu_wb.rob_id].br_mispred = alu_npc.mispred;
            end
        end
        if (ld_wb.valid) begin
            mdl[ld_wb.rob_id].reg_data = ld_wb.reg_data;
            mdl[ld_wb.rob_id].reg_ready = 1'b1;
            mdl[ld_wb.rob_id].is_executed = 1'b1;
        end

        exp_ret = '0;
        case (cmt)
            commit_reg: begin
                exp_ret.retire = 1'b1;
                exp_ret.rob_id = inflight[0];
                exp_ret.arf_id = head.dst_arf_id;
                exp_ret.reg_data = head.reg_data;
                mocc[inflight[0]] = 1'b0;
                void'(inflight.pop_front());
                n_retire++;
            end
            commit_silent: begin
                mocc[inflight[0]] = 1'b0;
                void'(inflight.pop_front());
                n_silent++;
            end
            commit_flush: begin
                exp_ret.redirect_valid = 1'b1;
                exp_ret.redirect_pc = head.pc_npc;
                // younger work is gone, numbering resumes after the branch
                mtail = rob_id_t'(inflight[0] + 1);
                foreach (inflight[i]) begin
                    mocc[inflight[i]] = 1'b0;
                end
                inflight.delete();
                n_flush++;
            end
            default: begin
            end
        endcase

        if (dispatch_valid && exp_ready) begin
            mdl[mtail] = '0;
            mdl[mtail].dst_valid = dispatch_data.dst_valid;
            mdl[mtail].dst_arf_id = dispatch_data.dst_arf_id;
            mdl[mtail].pc_npc = dispatch_data.pc;
            mocc[mtail] = 1'b1;
            inflight.push_back(mtail);
            mtail = rob_id_t'(mtail + 1);
        end
    endtask

    initial begin
        int guard;
        clk = 1'b0;
        rst_n = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_data = '0;
        iiq_wakeup = '0;
        alu_wb = '0;
        ld_wb = '0;
        alu_npc = '0;
        rd_id_src1 = '0;
        rd_id_src2 = '0;
        lcg_state = 32'h8782;
        exp_ret = '0;
        mtail = '0;
        n_full = 0;
        n_flush = 0;
        n_retire = 0;
        n_silent = 0;
        n_dual = 0;
        n_reads = 0;
        foreach (mocc[i]) begin
            mocc[i] = 1'b0;
        end

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // rotate fill, drain and mixed traffic
        for (int cyc = 0; cyc < 2400; cyc++) begin
            case ((cyc / 150) % 3)
                0: run_cycle(90, 10, 0);
                1: run_cycle(10, 90, 10);
                default: run_cycle(60, 50, 15);
            endcase
        end

        // finish everything still in flight
        guard = 0;
        while (inflight.size() != 0) begin
            if (guard >= 300) begin
                report_fail("timeout: reorder buffer did not drain within 300 cycles");
            end
            run_cycle(0, 100, 0);
            guard++;
        end
        run_cycle(0, 0, 0);

        if (n_full == 0 || n_flush == 0 || n_retire == 0 || n_silent == 0
                || n_dual == 0 || n_reads == 0) begin
            report_fail($sformatf(
                "scenario not reached: full=%0d flush=%0d retire=%0d silent=%0d dual=%0d reads=%0d",
                n_full, n_flush, n_retire, n_silent, n_dual, n_reads));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- logic/rob_top.sv
`default_nettype none

module rob_top (
    input wire clk,
    input wire rst_n,

    // dispatch, ready/valid
    input wire dispatch_valid,
    input wire rob_pkg::rob_dispatch_t dispatch_data,
    output wire dispatch_ready,
    output wire rob_pkg::rob_id_t dispatch_rob_id,

    // wakeup and writebacks
    input wire rob_pkg::rob_wb_t iiq_wakeup,
    input wire rob_pkg::rob_wb_t alu_wb,
    input wire rob_pkg::rob_wb_t ld_wb,
    input wire rob_pkg::rob_npc_t alu_npc,

    // operand reads
    input wire rob_pkg::rob_id_t rd_id_src1,
    input wire rob_pkg::rob_id_t rd_id_src2,
    output wire rob_pkg::rob_read_t rd_src1,
    output wire rob_pkg::rob_read_t rd_src2,

    // arf write and fetch redirect
    output wire rob_pkg::rob_retire_t retire_out
);
    import rob_pkg::*;

    wire enq_en;
    wire free_en;
    wire flush;
    wire rob_id_t head_id;
    wire rob_commit_e commit;
    wire rob_entry_t head_entry;
    wire head_occupied;

    // tail index doubles as the dispatch tag
    rob_queue_ctrl u_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .dispatch_valid(dispatch_valid),
        .head_entry(head_entry),
        .head_occupied(head_occupied),
        .dispatch_ready(dispatch_ready),
        .enq_en(enq_en),
        .tail_id(dispatch_rob_id),
        .free_en(free_en),
        .head_id(head_id),
        .flush(flush),
        .commit(commit)
    );

    rob_entry_array u_array (
        .clk(clk),
        .rst_n(rst_n),
        .enq_en(enq_en),
        .tail_id(dispatch_rob_id),
        .dispatch_data(dispatch_data),
        .iiq_wakeup(iiq_wakeup),
        .alu_wb(alu_wb),
        .ld_wb(ld_wb),
        .alu_npc(alu_npc),
        .free_en(free_en),
        .head_id(head_id),
        .flush(flush),
        .rd_id_src1(rd_id_src1),
        .rd_id_src2(rd_id_src2),
        .rd_src1(rd_src1),
        .rd_src2(rd_src2),
        .head_entry(head_entry),
        .head_occupied(head_occupied)
    );

    // registered at the same edge that frees the head
    rob_retire_unit u_retire (
        .clk(clk),
        .rst_n(rst_n),
        .commit(commit),
        .head_id(head_id),
        .head_entry(head_entry),
        .retire_out(retire_out)
    );

endmodule

`default_nettype wire

//--- logic/rob_retire_unit.sv
`default_nettype none

module rob_retire_unit (
    input wire clk,
    input wire rst_n,
    input wire rob_pkg::rob_commit_e commit,
    input wire rob_pkg::rob_id_t head_id,
    input wire rob_pkg::rob_entry_t head_entry,
    output rob_pkg::rob_retire_t retire_out
);
    import rob_pkg::*;

    logic retire_q;
    logic redirect_q;
    rob_id_t rob_id_q;
    arf_id_t arf_id_q;
    reg_data_t reg_data_q;
    addr_t redirect_pc_q;

    // pulse bits, one cycle per commit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_q <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            retire_q <= (commit == commit_reg);
            redirect_q <= (commit == commit_flush);
        end
    end

    // payload, only meaningful alongside a pulse
    always_ff @(posedge clk) begin
        rob_id_q <= head_id;
        arf_id_q <= head_entry.dst_arf_id;
        reg_data_q <= head_entry.reg_data;
        // npc of the mispredicted branch
        redirect_pc_q <= head_entry.pc_npc;
    end

    always_comb begin
        retire_out.retire = retire_q;
        retire_out.rob_id = rob_id_q;
        retire_out.arf_id = arf_id_q;
        retire_out.reg_data = reg_data_q;
        retire_out.redirect_valid = redirect_q;
        retire_out.redirect_pc = redirect_pc_q;
    end

    a_retire_xor_redirect : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(retire_out.retire && retire_out.redirect_valid)
    ) else $error("retire and redirect in the same cycle");

endmodule

`default_nettype wire

//--- logic/rob_entry_array.sv
`default_nettype none

`include "rob_params.svh"

module rob_entry_array (
    input wire clk,
    input wire rst_n,

    // dispatch write at the tail
    input wire enq_en,
    input wire rob_pkg::rob_id_t tail_id,
    input wire rob_pkg::rob_dispatch_t dispatch_data,

    // result writes
    input wire rob_pkg::rob_wb_t iiq_wakeup,
    input wire rob_pkg::rob_wb_t alu_wb,
    input wire rob_pkg::rob_wb_t ld_wb,
    input wire rob_pkg::rob_npc_t alu_npc,

    // release at the head, or everything on flush
    input wire free_en,
    input wire rob_pkg::rob_id_t head_id,
    input wire flush,

    // operand read ports
    input wire rob_pkg::rob_id_t rd_id_src1,
    input wire rob_pkg::rob_id_t rd_id_src2,
    output rob_pkg::rob_read_t rd_src1,
    output rob_pkg::rob_read_t rd_src2,

    // head view for the commit decision
    output rob_pkg::rob_entry_t head_entry,
    output logic head_occupied
);
    import rob_pkg::*;

    rob_entry_t [`ROB_N_ENTRIES-1:0] entries_q;
    rob_entry_t [`ROB_N_ENTRIES-1:0] entries_d;
    logic [`ROB_N_ENTRIES-1:0] occupied_q;
    logic [`ROB_N_ENTRIES-1:0] occupied_d;
    rob_entry_t new_entry;

    // fresh slot, nothing executed or ready yet
    always_comb begin
        new_entry = '0;
        new_entry.dst_valid = dispatch_data.dst_valid;
        new_entry.dst_arf_id = dispatch_data.dst_arf_id;
        new_entry.pc_npc = dispatch_data.pc;
    end

    // merge results into live slots
    // wakeup first so the alu and load writes win on the same slot
    always_comb begin
        entries_d = entries_q;
        for (int i = 0; i < `ROB_N_ENTRIES; i++) begin
            if (occupied_q[i] && iiq_wakeup.valid && iiq_wakeup.rob_id == rob_id_t'(i)) begin
                entries_d[i].reg_ready = 1'b1;
            end
            if (occupied_q[i] && alu_wb.valid && alu_wb.rob_id == rob_id_t'(i)) begin
                entries_d[i].reg_data = alu_wb.reg_data;
                entries_d[i].is_executed = 1'b1;
                // branch result, npc goes where the pc was
                if (alu_npc.valid) begin
                    entries_d[i].pc_npc = alu_npc.npc;
                    entries_d[i].br_mispred = alu_npc.mispred;
                end
            end
            if (occupied_q[i] && ld_wb.valid && ld_wb.rob_id == rob_id_t'(i)) begin
                // load data also wakes dependents
                entries_d[i].reg_data = ld_wb.reg_data;
                entries_d[i].reg_ready = 1'b1;
                entries_d[i].is_executed = 1'b1;
            end
        end
        // tail slot is empty, so no result lands there
        if (enq_en) begin
            entries_d[tail_id] = new_entry;
        end
    end

    always_comb begin
        occupied_d = occupied_q;
        if (free_en) begin
            occupied_d[head_id] = 1'b0;
        end
        if (enq_en) begin
            occupied_d[tail_id] = 1'b1;
        end
        // mispredict drops every slot
        if (flush) begin
            occupied_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        entries_q <= entries_d;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupied_q <= '0;
        end else begin
            occupied_q <= occupied_d;
        end
    end

    // combinational lookups
    assign rd_src1.reg_ready = entries_q[rd_id_src1].reg_ready;
    assign rd_src1.reg_data = entries_q[rd_id_src1].reg_data;
    assign rd_src2.reg_ready = entries_q[rd_id_src2].reg_ready;
    assign rd_src2.reg_data = entries_q[rd_id_src2].reg_data;

    assign head_entry = entries_q[head_id];
    assign head_occupied = occupied_q[head_id];

    // alu and load unit must target different slots
    a_no_wb_collision : assert property (
        @(posedge clk) disable iff (!rst_n)
        (alu_wb.valid && ld_wb.valid) |-> (alu_wb.rob_id != ld_wb.rob_id)
    ) else $error("alu and load writeback on the same rob entry");

endmodule

`default_nettype wire

//--- logic/rob_queue_ctrl.sv
`default_nettype none

`include "rob_params.svh"

module rob_queue_ctrl (
    input wire clk,
    input wire rst_n,
    input wire dispatch_valid,

    // head slot as stored in the array
    input wire rob_pkg::rob_entry_t head_entry,
    input wire head_occupied,

    output logic dispatch_ready,
    output logic enq_en,
    output rob_pkg::rob_id_t tail_id,
    output logic free_en,
    output rob_pkg::rob_id_t head_id,
    output logic flush,
    output rob_pkg::rob_commit_e commit
);
    import rob_pkg::*;

    localparam logic [`ROB_ID_WIDTH:0] rob_depth = `ROB_N_ENTRIES;
    localparam rob_id_t last_id = rob_id_t'(`ROB_N_ENTRIES - 1);

    rob_id_t head_q;
    rob_id_t tail_q;
    rob_id_t head_next;
    rob_id_t tail_next;
    logic [`ROB_ID_WIDTH:0] count_q;
    logic full;

    // wrap at the last slot
    assign head_next = (head_q == last_id) ? '0 : head_q + 1'b1;
    assign tail_next = (tail_q == last_id) ? '0 : tail_q + 1'b1;

    assign full = (count_q == rob_depth);

    // head commit decision
    always_comb begin
        if (!head_occupied || !head_entry.is_executed) begin
            commit = commit_none;
        end else if (head_entry.br_mispred) begin
            commit = commit_flush;
        end else if (head_entry.dst_valid) begin
            commit = commit_reg;
        end else begin
            // store or correctly predicted branch
            commit = commit_silent;
        end
    end

    // no accept while flushing
    assign dispatch_ready = !full && (commit != commit_flush);
    assign enq_en = dispatch_valid && dispatch_ready;
    assign free_en = (commit != commit_none);
    assign flush = (commit == commit_flush);

    assign head_id = head_q;
    assign tail_id = tail_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else if (flush) begin
            // restart empty just past the mispredicted branch
            head_q <= head_next;
            tail_q <= head_next;
            count_q <= '0;
        end else begin
            if (free_en) begin
                head_q <= head_next;
            end
            if (enq_en) begin
                tail_q <= tail_next;
            end
            case ({enq_en, free_en})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        count_q <= rob_depth
    ) else $error("rob occupancy above depth");

    // array occupancy and controller count must agree
    a_no_free_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        free_en |-> (count_q != '0)
    ) else $error("rob head freed while empty");

endmodule

`default_nettype wire

//--- logic/rob_pkg.sv
`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`ARF_ID_WIDTH-1:0] arf_id_t;
    typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // instruction as it leaves dispatch
    typedef struct packed {
        logic dst_valid;
        arf_id_t dst_arf_id;
        addr_t pc;
    } rob_dispatch_t;

    // one buffer slot
    // pc_npc holds the pc until a branch result replaces it with the npc
    typedef struct packed {
        logic dst_valid;
        arf_id_t dst_arf_id;
        addr_t pc_npc;
        logic br_mispred;
        logic reg_ready;
        logic is_executed;
        reg_data_t reg_data;
    } rob_entry_t;

    // result write, reg_data unused for wakeup
    typedef struct packed {
        logic valid;
        rob_id_t rob_id;
        reg_data_t reg_data;
    } rob_wb_t;

    // alu branch outcome, travels with alu_wb
    typedef struct packed {
        logic valid;
        logic mispred;
        addr_t npc;
    } rob_npc_t;

    // source operand lookup answer
    typedef struct packed {
        logic reg_ready;
        reg_data_t reg_data;
    } rob_read_t;

    // retire toward the arf, redirect toward fetch
    typedef struct packed {
        logic retire;
        rob_id_t rob_id;
        arf_id_t arf_id;
        reg_data_t reg_data;
        logic redirect_valid;
        addr_t redirect_pc;
    } rob_retire_t;

    // what the head does this cycle
    typedef enum logic [1:0] {
        commit_none,
        commit_reg,
        commit_silent,
        commit_flush
    } rob_commit_e;

endpackage

`default_nettype wire

//--- logic/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// reorder buffer sizing

// number of in-flight instructions
`define ROB_N_ENTRIES 8

// index into the buffer, log2 of the depth
`define ROB_ID_WIDTH 3

// architectural register number
`define ARF_ID_WIDTH 5

// integer register value
`define REG_DATA_WIDTH 32

// instruction address
`define ADDR_WIDTH 32

`endif
